/* dma_transport_layer.f */
+incdir+rtl
rtl/dma_bus_pkg.sv
rtl/dma_dp_pkg.sv
rtl/dma_obi_read.sv
rtl/dma_byte_buffer.sv
rtl/dma_obi_write.sv
rtl/dma_transport_layer.sv
testbench/tb_clk_gen.sv
testbench/dma_transport_layer_chk.sv
testbench/tb_dma_transport_layer.sv

/* rtl/dma_bus_pkg.sv */
`include "dma_cfg.svh"

package dma_bus_pkg;

    // OBI address and data
    typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DMA_DATA_WIDTH-1:0] data_t;

    // One enable bit per byte lane
    typedef logic [`DMA_STRB_WIDTH-1:0] be_t;

    typedef logic [7:0] byte_t;

endpackage

/* rtl/dma_byte_buffer.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_byte_buffer (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  dma_bus_pkg::data_t     push_data_i,
    input  dma_dp_pkg::lane_mask_t push_mask_i,
    output dma_dp_pkg::lane_mask_t push_ready_o,
    output dma_bus_pkg::data_t     pop_data_o,
    output dma_dp_pkg::lane_mask_t pop_valid_o,
    input  dma_dp_pkg::lane_mask_t pop_mask_i
);

    import dma_bus_pkg::*;

    localparam int unsigned DEPTH = `DMA_BUF_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ------------------------------------------------------------------
    // One FIFO per byte lane, so lanes fill and drain independently
    // ------------------------------------------------------------------
    for (genvar l = 0; l < `DMA_STRB_WIDTH; l++) begin : gen_lane
        byte_t            mem_q [DEPTH];
        logic [PTR_W-1:0] wr_ptr_q;
        logic [PTR_W-1:0] rd_ptr_q;
        logic [CNT_W-1:0] cnt_q;
        logic             push;
        logic             pop;

        assign push_ready_o[l] = (cnt_q != CNT_W'(DEPTH));
        assign pop_valid_o[l]  = (cnt_q != '0);
        assign push            = push_mask_i[l] && push_ready_o[l];
        assign pop             = pop_mask_i[l] && pop_valid_o[l];

        assign pop_data_o[8*l +: 8] = mem_q[rd_ptr_q];

        always_ff @(posedge clk_i) begin
            if (push) begin
                mem_q[wr_ptr_q] <= push_data_i[8*l +: 8];
            end
        end

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                cnt_q    <= '0;
            end else begin
                if (push) begin
                    wr_ptr_q <= next_ptr(wr_ptr_q);
                end
                if (pop) begin
                    rd_ptr_q <= next_ptr(rd_ptr_q);
                end
                // Simultaneous push and pop leaves the count alone
                case ({push, pop})
                    2'b10:   cnt_q <= cnt_q + 1'b1;
                    2'b01:   cnt_q <= cnt_q - 1'b1;
                    default: cnt_q <= cnt_q;
                endcase
            end
        end
    end

endmodule

/* rtl/dma_cfg.svh */
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Bus widths
`define DMA_DATA_WIDTH 32
`define DMA_ADDR_WIDTH 32

// Byte lanes per data word
`define DMA_STRB_WIDTH (`DMA_DATA_WIDTH / 8)

// Entries in each byte-lane FIFO
`define DMA_BUF_DEPTH 3

`endif

/* rtl/dma_dp_pkg.sv */
`include "dma_cfg.svh"

package dma_dp_pkg;

    localparam int unsigned STRB = `DMA_STRB_WIDTH;

    // Offset, tailer and shift all index a byte lane
    typedef logic [$clog2(STRB)-1:0] lane_t;
    typedef logic [STRB-1:0]         lane_mask_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA,
        RD_RESP
    } rd_state_e;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_WAIT_DATA,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    // Valid lanes run from offset up to the last lane minus tailer
    function automatic lane_mask_t lane_mask(lane_t offset, lane_t tailer);
        lane_mask_t mask;
        for (int j = 0; j < STRB; j++) begin
            mask[j] = (j >= offset) && (j <= (STRB - 1 - tailer));
        end
        return mask;
    endfunction

    // Lane j takes lane (j + shift) mod STRB
    function automatic dma_bus_pkg::data_t rotate_bytes(dma_bus_pkg::data_t data,
                                                        lane_t shift);
        dma_bus_pkg::data_t rot;
        int unsigned        src;
        for (int j = 0; j < STRB; j++) begin
            src = (j + shift) % STRB;
            rot[8*j +: 8] = data[8*src +: 8];
        end
        return rot;
    endfunction

    function automatic lane_mask_t rotate_mask(lane_mask_t mask, lane_t shift);
        lane_mask_t rot;
        for (int j = 0; j < STRB; j++) begin
            rot[j] = mask[(j + shift) % STRB];
        end
        return rot;
    endfunction

endpackage

/* rtl/dma_obi_read.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_obi_read (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // Read meta channel
    input  dma_bus_pkg::addr_t     ar_addr_i,
    input  logic                   ar_valid_i,
    output logic                   ar_ready_o,
    // Datapath request and response
    input  dma_dp_pkg::lane_t      r_dp_offset_i,
    input  dma_dp_pkg::lane_t      r_dp_tailer_i,
    input  dma_dp_pkg::lane_t      r_dp_shift_i,
    input  logic                   r_dp_valid_i,
    output logic                   r_dp_ready_o,
    output logic                   r_dp_err_o,
    output logic                   r_dp_valid_o,
    input  logic                   r_dp_ready_i,
    // OBI read bus
    output logic                   rd_req_o,
    output dma_bus_pkg::addr_t     rd_addr_o,
    input  logic                   rd_gnt_i,
    input  logic                   rd_rvalid_i,
    input  logic                   rd_err_i,
    input  dma_bus_pkg::data_t     rd_rdata_i,
    output logic                   rd_rready_o,
    // Buffer push side
    output dma_bus_pkg::data_t     push_data_o,
    output dma_dp_pkg::lane_mask_t push_mask_o,
    input  dma_dp_pkg::lane_mask_t push_ready_i
);

    import dma_bus_pkg::*;
    import dma_dp_pkg::*;

    rd_state_e  state_q, state_d;
    addr_t      addr_q;
    lane_t      shift_q;
    lane_mask_t mask_q;
    logic       err_q;
    logic       meta_hs;
    logic       rdata_hs;

    // Meta beat and datapath request are taken together
    assign ar_ready_o   = (state_q == RD_IDLE) && r_dp_valid_i;
    assign r_dp_ready_o = (state_q == RD_IDLE) && ar_valid_i;
    assign meta_hs      = ar_valid_i && ar_ready_o;

    assign rd_req_o  = (state_q == RD_ADDR);
    assign rd_addr_o = addr_q;

    // Only take read data once every masked lane has room
    assign rd_rready_o = (state_q == RD_DATA) && (&(push_ready_i | ~mask_q));
    assign rdata_hs    = rd_rvalid_i && rd_rready_o;

    assign push_data_o = rotate_bytes(rd_rdata_i, shift_q);
    assign push_mask_o = rdata_hs ? mask_q : '0;

    assign r_dp_valid_o = (state_q == RD_RESP);
    assign r_dp_err_o   = err_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: if (meta_hs)      state_d = RD_ADDR;
            RD_ADDR: if (rd_gnt_i)     state_d = RD_DATA;
            RD_DATA: if (rdata_hs)     state_d = RD_RESP;
            RD_RESP: if (r_dp_ready_i) state_d = RD_IDLE;
            default:                   state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RD_IDLE;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (rdata_hs) begin
                err_q <= rd_err_i;
            end
        end
    end

    // Request fields for the beat in flight
    always_ff @(posedge clk_i) begin
        if (meta_hs) begin
            addr_q  <= ar_addr_i;
            shift_q <= r_dp_shift_i;
            mask_q  <= lane_mask(r_dp_offset_i, r_dp_tailer_i);
        end
    end

endmodule

/* rtl/dma_obi_write.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_obi_write (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // Write meta channel
    input  dma_bus_pkg::addr_t     aw_addr_i,
    input  logic                   aw_valid_i,
    output logic                   aw_ready_o,
    // Datapath request and response
    input  dma_dp_pkg::lane_t      w_dp_offset_i,
    input  dma_dp_pkg::lane_t      w_dp_tailer_i,
    input  dma_dp_pkg::lane_t      w_dp_shift_i,
    input  logic                   w_dp_valid_i,
    output logic                   w_dp_ready_o,
    output logic                   w_dp_err_o,
    output logic                   w_dp_valid_o,
    input  logic                   w_dp_ready_i,
    // OBI write bus
    output logic                   wr_req_o,
    output dma_bus_pkg::addr_t     wr_addr_o,
    output dma_bus_pkg::data_t     wr_wdata_o,
    output dma_bus_pkg::be_t       wr_be_o,
    input  logic                   wr_gnt_i,
    input  logic                   wr_rvalid_i,
    input  logic                   wr_err_i,
    // Buffer pop side
    input  dma_bus_pkg::data_t     pop_data_i,
    input  dma_dp_pkg::lane_mask_t pop_valid_i,
    output dma_dp_pkg::lane_mask_t pop_mask_o
);

    import dma_bus_pkg::*;
    import dma_dp_pkg::*;

    wr_state_e  state_q, state_d;
    addr_t      addr_q;
    lane_t      shift_q;
    lane_mask_t mask_q;
    logic       err_q;
    logic       meta_hs;
    logic       data_avail;
    data_t      wdata_rot;

    assign aw_ready_o   = (state_q == WR_IDLE) && w_dp_valid_i;
    assign w_dp_ready_o = (state_q == WR_IDLE) && aw_valid_i;
    assign meta_hs      = aw_valid_i && aw_ready_o;

    // All masked buffer lanes hold a byte
    assign data_avail = &(pop_valid_i | ~mask_q);

    // ------------------------------------------------------------------
    // Bus lanes and enables
    // ------------------------------------------------------------------
    assign wr_req_o  = (state_q == WR_ADDR);
    assign wr_addr_o = addr_q;
    assign wr_be_o   = rotate_mask(mask_q, shift_q);

    // Lanes without an enable are driven to zero
    always_comb begin
        wdata_rot = rotate_bytes(pop_data_i, shift_q);
        for (int k = 0; k < STRB; k++) begin
            wr_wdata_o[8*k +: 8] = wr_be_o[k] ? wdata_rot[8*k +: 8] : 8'h00;
        end
    end

    // Buffer is drained on the grant cycle
    assign pop_mask_o = (wr_req_o && wr_gnt_i) ? mask_q : '0;

    assign w_dp_valid_o = (state_q == WR_RESP);
    assign w_dp_err_o   = err_q;

    // ------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE:      if (meta_hs)      state_d = WR_WAIT_DATA;
            WR_WAIT_DATA: if (data_avail)   state_d = WR_ADDR;
            WR_ADDR:      if (wr_gnt_i)     state_d = WR_DATA;
            WR_DATA:      if (wr_rvalid_i)  state_d = WR_RESP;
            WR_RESP:      if (w_dp_ready_i) state_d = WR_IDLE;
            default:                        state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= WR_IDLE;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if ((state_q == WR_DATA) && wr_rvalid_i) begin
                err_q <= wr_err_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (meta_hs) begin
            addr_q  <= aw_addr_i;
            shift_q <= w_dp_shift_i;
            mask_q  <= lane_mask(w_dp_offset_i, w_dp_tailer_i);
        end
    end

endmodule

/* rtl/dma_transport_layer.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_transport_layer (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // Read meta and datapath
    input  dma_bus_pkg::addr_t ar_addr_i,
    input  logic               ar_valid_i,
    output logic               ar_ready_o,
    input  dma_dp_pkg::lane_t  r_dp_offset_i,
    input  dma_dp_pkg::lane_t  r_dp_tailer_i,
    input  dma_dp_pkg::lane_t  r_dp_shift_i,
    input  logic               r_dp_valid_i,
    output logic               r_dp_ready_o,
    output logic               r_dp_err_o,
    output logic               r_dp_valid_o,
    input  logic               r_dp_ready_i,
    // OBI read bus
    output logic               rd_req_o,
    output dma_bus_pkg::addr_t rd_addr_o,
    input  logic               rd_gnt_i,
    input  logic               rd_rvalid_i,
    input  logic               rd_err_i,
    input  dma_bus_pkg::data_t rd_rdata_i,
    output logic               rd_rready_o,
    // Write meta and datapath
    input  dma_bus_pkg::addr_t aw_addr_i,
    input  logic               aw_valid_i,
    output logic               aw_ready_o,
    input  dma_dp_pkg::lane_t  w_dp_offset_i,
    input  dma_dp_pkg::lane_t  w_dp_tailer_i,
    input  dma_dp_pkg::lane_t  w_dp_shift_i,
    input  logic               w_dp_valid_i,
    output logic               w_dp_ready_o,
    output logic               w_dp_err_o,
    output logic               w_dp_valid_o,
    input  logic               w_dp_ready_i,
    // OBI write bus
    output logic               wr_req_o,
    output dma_bus_pkg::addr_t wr_addr_o,
    output dma_bus_pkg::data_t wr_wdata_o,
    output dma_bus_pkg::be_t   wr_be_o,
    input  logic               wr_gnt_i,
    input  logic               wr_rvalid_i,
    input  logic               wr_err_i,
    // Status
    output logic               r_dp_busy_o,
    output logic               w_dp_busy_o,
    output logic               buffer_busy_o
);

    import dma_bus_pkg::*;
    import dma_dp_pkg::*;

    // Read port into buffer
    data_t      push_data;
    lane_mask_t push_mask;
    lane_mask_t push_ready;

    // Buffer into write port
    data_t      pop_data;
    lane_mask_t pop_valid;
    lane_mask_t pop_mask;

    // ------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------
    dma_obi_read i_obi_read (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .ar_addr_i     ( ar_addr_i     ),
        .ar_valid_i    ( ar_valid_i    ),
        .ar_ready_o    ( ar_ready_o    ),
        .r_dp_offset_i ( r_dp_offset_i ),
        .r_dp_tailer_i ( r_dp_tailer_i ),
        .r_dp_shift_i  ( r_dp_shift_i  ),
        .r_dp_valid_i  ( r_dp_valid_i  ),
        .r_dp_ready_o  ( r_dp_ready_o  ),
        .r_dp_err_o    ( r_dp_err_o    ),
        .r_dp_valid_o  ( r_dp_valid_o  ),
        .r_dp_ready_i  ( r_dp_ready_i  ),
        .rd_req_o      ( rd_req_o      ),
        .rd_addr_o     ( rd_addr_o     ),
        .rd_gnt_i      ( rd_gnt_i      ),
        .rd_rvalid_i   ( rd_rvalid_i   ),
        .rd_err_i      ( rd_err_i      ),
        .rd_rdata_i    ( rd_rdata_i    ),
        .rd_rready_o   ( rd_rready_o   ),
        .push_data_o   ( push_data     ),
        .push_mask_o   ( push_mask     ),
        .push_ready_i  ( push_ready    )
    );

    // ------------------------------------------------------------------
    // Reorder buffer
    // ------------------------------------------------------------------
    dma_byte_buffer i_byte_buffer (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .push_data_i  ( push_data  ),
        .push_mask_i  ( push_mask  ),
        .push_ready_o ( push_ready ),
        .pop_data_o   ( pop_data   ),
        .pop_valid_o  ( pop_valid  ),
        .pop_mask_i   ( pop_mask   )
    );

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------
    dma_obi_write i_obi_write (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .aw_addr_i     ( aw_addr_i     ),
        .aw_valid_i    ( aw_valid_i    ),
        .aw_ready_o    ( aw_ready_o    ),
        .w_dp_offset_i ( w_dp_offset_i ),
        .w_dp_tailer_i ( w_dp_tailer_i ),
        .w_dp_shift_i  ( w_dp_shift_i  ),
        .w_dp_valid_i  ( w_dp_valid_i  ),
        .w_dp_ready_o  ( w_dp_ready_o  ),
        .w_dp_err_o    ( w_dp_err_o    ),
        .w_dp_valid_o  ( w_dp_valid_o  ),
        .w_dp_ready_i  ( w_dp_ready_i  ),
        .wr_req_o      ( wr_req_o      ),
        .wr_addr_o     ( wr_addr_o     ),
        .wr_wdata_o    ( wr_wdata_o    ),
        .wr_be_o       ( wr_be_o       ),
        .wr_gnt_i      ( wr_gnt_i      ),
        .wr_rvalid_i   ( wr_rvalid_i   ),
        .wr_err_i      ( wr_err_i      ),
        .pop_data_i    ( pop_data      ),
        .pop_valid_i   ( pop_valid     ),
        .pop_mask_o    ( pop_mask      )
    );

    // Busy while a request waits or bytes sit in the buffer
    assign r_dp_busy_o   = r_dp_valid_i;
    assign w_dp_busy_o   = w_dp_valid_i;
    assign buffer_busy_o = |pop_valid;

endmodule

/* testbench/dma_transport_layer_chk.sv */
`timescale 1ns/1ps

module dma_transport_layer_chk (
    input logic               clk_i,
    input logic               rst_n_i,
    input logic               rd_req_o,
    input dma_bus_pkg::addr_t rd_addr_o,
    input logic               rd_gnt_i,
    input logic               rd_rready_o,
    input logic               wr_req_o,
    input dma_bus_pkg::addr_t wr_addr_o,
    input dma_bus_pkg::data_t wr_wdata_o,
    input dma_bus_pkg::be_t   wr_be_o,
    input logic               wr_gnt_i,
    input logic               r_dp_valid_o,
    input logic               r_dp_err_o,
    input logic               r_dp_ready_i,
    input logic               w_dp_valid_o,
    input logic               w_dp_err_o,
    input logic               w_dp_ready_i,
    input logic               r_dp_busy_o,
    input logic               w_dp_busy_o,
    input logic               buffer_busy_o
);

    // Failed assertions so far
    int unsigned fail_cnt = 0;

    // ------------------------------------------------------------------
    // OBI requests hold until granted
    // ------------------------------------------------------------------
    rd_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rd_req_o && !rd_gnt_i |=> rd_req_o && $stable(rd_addr_o))
        else begin
            fail_cnt++;
            $error("read request dropped or changed before grant");
        end

    wr_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_req_o && !wr_gnt_i |=> wr_req_o && $stable(wr_addr_o)
                                  && $stable(wr_wdata_o) && $stable(wr_be_o))
        else begin
            fail_cnt++;
            $error("write request dropped or changed before grant");
        end

    // ------------------------------------------------------------------
    // Datapath responses hold until taken
    // ------------------------------------------------------------------
    r_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        r_dp_valid_o && !r_dp_ready_i |=> r_dp_valid_o && $stable(r_dp_err_o))
        else begin
            fail_cnt++;
            $error("read response dropped or changed before ready");
        end

    w_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        w_dp_valid_o && !w_dp_ready_i |=> w_dp_valid_o && $stable(w_dp_err_o))
        else begin
            fail_cnt++;
            $error("write response dropped or changed before ready");
        end

    // Quiet outputs in reset and on the first cycle out of it
    reset_idle: assert property (@(posedge clk_i)
        !rst_n_i || $rose(rst_n_i) |-> !rd_req_o && !wr_req_o && !rd_rready_o
            && !r_dp_valid_o && !w_dp_valid_o
            && !r_dp_busy_o && !w_dp_busy_o && !buffer_busy_o)
        else begin
            fail_cnt++;
            $error("outputs not idle around reset");
        end

endmodule

bind dma_transport_layer dma_transport_layer_chk i_chk (.*);

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // Three rising edges in reset, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

/* testbench/tb_dma_transport_layer.sv */
`timescale 1ns/1ps

module tb_dma_transport_layer;

    import dma_bus_pkg::*;
    import dma_dp_pkg::*;

    localparam int    TIMEOUT  = 200;
    localparam int    N_RANDOM = 40;
    localparam addr_t ERR_BASE = 32'h0000_0F00;

    logic  clk_i, rst_n_i;
    addr_t ar_addr_i, aw_addr_i, rd_addr_o, wr_addr_o;
    logic  ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o;
    lane_t r_dp_offset_i, r_dp_tailer_i, r_dp_shift_i;
    lane_t w_dp_offset_i, w_dp_tailer_i, w_dp_shift_i;
    logic  r_dp_valid_i, r_dp_ready_o, r_dp_err_o, r_dp_valid_o, r_dp_ready_i;
    logic  w_dp_valid_i, w_dp_ready_o, w_dp_err_o, w_dp_valid_o, w_dp_ready_i;
    logic  rd_req_o, rd_gnt_i, rd_rvalid_i, rd_err_i, rd_rready_o;
    data_t rd_rdata_i, wr_wdata_o;
    logic  wr_req_o, wr_gnt_i, wr_rvalid_i, wr_err_i;
    be_t   wr_be_o;
    logic  r_dp_busy_o, w_dp_busy_o, buffer_busy_o;

    // Source words and destination bytes
    data_t rd_mem [1024];
    byte_t wr_mem [4096];

    int seed        = 7150;
    int err_cnt     = 0;
    int timeout_cnt = 0;
    int copy_cnt    = 0;

    tb_clk_gen i_clk_gen (.clk_o(clk_i), .rst_n_o(rst_n_i));

    dma_transport_layer uut (.*);

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic report_and_stop();
        int unsigned chk_fails;
        chk_fails = uut.i_chk.fail_cnt;
        $display("copies %0d, data errors %0d, timeouts %0d, protocol failures %0d",
                 copy_cnt, err_cnt, timeout_cnt, chk_fails);
        if (err_cnt == 0 && timeout_cnt == 0 && chk_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        timeout_cnt++;
        report_and_stop();
    endtask

    // ------------------------------------------------------------------
    // OBI read memory
    // ------------------------------------------------------------------
    initial begin
        addr_t raddr;
        int    n;
        rd_gnt_i    = 1'b0;
        rd_rvalid_i = 1'b0;
        rd_err_i    = 1'b0;
        rd_rdata_i  = '0;
        forever begin
            @(negedge clk_i);
            if (rd_req_o) begin
                repeat (rand_below(4)) @(negedge clk_i);
                rd_gnt_i = 1'b1;
                raddr    = rd_addr_o;
                @(negedge clk_i);
                rd_gnt_i = 1'b0;
                repeat (rand_below(3)) @(negedge clk_i);
                rd_rvalid_i = 1'b1;
                rd_rdata_i  = rd_mem[raddr[11:2]];
                rd_err_i    = (raddr >= ERR_BASE);
                n = 0;
                // Data stays on the bus until the port has room for it
                while (!rd_rready_o) begin
                    if (n == TIMEOUT) abort_on_timeout("read data ready");
                    @(negedge clk_i);
                    n++;
                end
                @(negedge clk_i);
                rd_rvalid_i = 1'b0;
                rd_err_i    = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // OBI write memory
    // ------------------------------------------------------------------
    initial begin
        addr_t waddr;
        data_t wdata;
        be_t   wbe;
        wr_gnt_i    = 1'b0;
        wr_rvalid_i = 1'b0;
        wr_err_i    = 1'b0;
        forever begin
            @(negedge clk_i);
            if (wr_req_o) begin
                repeat (rand_below(4)) @(negedge clk_i);
                wr_gnt_i = 1'b1;
                waddr    = wr_addr_o;
                wdata    = wr_wdata_o;
                wbe      = wr_be_o;
                // Masked bytes still sit in the buffer until this grant
                assert (buffer_busy_o) else begin
                    err_cnt++;
                    $display("error %0t: buffer not busy while a write is pending", $time);
                end
                @(negedge clk_i);
                wr_gnt_i = 1'b0;
                for (int k = 0; k < 4; k++) begin
                    assert (wbe[k] || wdata[8*k +: 8] == 8'h00) else begin
                        err_cnt++;
                        $display("error %0t: disabled lane %0d carries %02h",
                                 $time, k, wdata[8*k +: 8]);
                    end
                    if (wbe[k] && waddr < ERR_BASE) begin
                        wr_mem[{waddr[11:2], 2'(k)}] = wdata[8*k +: 8];
                    end
                end
                repeat (rand_below(3)) @(negedge clk_i);
                wr_rvalid_i = 1'b1;
                wr_err_i    = (waddr >= ERR_BASE);
                @(negedge clk_i);
                wr_rvalid_i = 1'b0;
                wr_err_i    = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus per port
    // ------------------------------------------------------------------
    task automatic read_side(input addr_t src, input lane_t off, input lane_t tail,
                             input lane_t shift, output logic err);
        int   n;
        logic done;
        ar_addr_i     = src;
        ar_valid_i    = 1'b1;
        r_dp_offset_i = off;
        r_dp_tailer_i = tail;
        r_dp_shift_i  = shift;
        r_dp_valid_i  = 1'b1;
        n = 0;
        #1;
        while (!(ar_ready_o && r_dp_ready_o)) begin
            if (n == TIMEOUT) abort_on_timeout("read request accept");
            @(negedge clk_i);
            #1;
            n++;
        end
        assert (r_dp_busy_o) else begin
            err_cnt++;
            $display("error %0t: read busy flag low with a pending request", $time);
        end
        @(negedge clk_i);
        ar_valid_i   = 1'b0;
        r_dp_valid_i = 1'b0;
        n    = 0;
        done = 1'b0;
        // Response ready toggles at random
        while (!done) begin
            if (n == TIMEOUT) abort_on_timeout("read response");
            r_dp_ready_i = (rand_below(3) == 0);
            #1;
            done = r_dp_valid_o && r_dp_ready_i;
            err  = r_dp_err_o;
            @(negedge clk_i);
            n++;
        end
        r_dp_ready_i = 1'b0;
    endtask

    task automatic write_side(input addr_t dst, input lane_t off, input lane_t tail,
                              input lane_t shift, output logic err);
        int   n;
        logic done;
        aw_addr_i     = dst;
        aw_valid_i    = 1'b1;
        w_dp_offset_i = off;
        w_dp_tailer_i = tail;
        w_dp_shift_i  = shift;
        w_dp_valid_i  = 1'b1;
        n = 0;
        #1;
        while (!(aw_ready_o && w_dp_ready_o)) begin
            if (n == TIMEOUT) abort_on_timeout("write request accept");
            @(negedge clk_i);
            #1;
            n++;
        end
        assert (w_dp_busy_o) else begin
            err_cnt++;
            $display("error %0t: write busy flag low with a pending request", $time);
        end
        @(negedge clk_i);
        aw_valid_i   = 1'b0;
        w_dp_valid_i = 1'b0;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            if (n == TIMEOUT) abort_on_timeout("write response");
            w_dp_ready_i = (rand_below(3) == 0);
            #1;
            done = w_dp_valid_o && w_dp_ready_i;
            err  = w_dp_err_o;
            @(negedge clk_i);
            n++;
        end
        w_dp_ready_i = 1'b0;
    endtask

    // One beat from src to dst, same buffer lanes on both sides
    task automatic run_copy(input addr_t src, input addr_t dst, input lane_t off,
                            input lane_t tail, input lane_t rs, input lane_t ws);
        data_t src_word;
        byte_t exp_b [4];
        int    b;
        logic  r_err;
        logic  w_err;
        src_word = rd_mem[src[11:2]];
        for (int k = 0; k < 4; k++) begin
            b        = (k + ws) % 4;
            exp_b[k] = wr_mem[{dst[11:2], 2'(k)}];
            if (dst < ERR_BASE && b >= off && b <= 3 - tail) begin
                exp_b[k] = src_word[8*((b + rs) % 4) +: 8];
            end
        end
        fork
            read_side(src, off, tail, rs, r_err);
            write_side(dst, off, tail, ws, w_err);
        join
        for (int k = 0; k < 4; k++) begin
            assert (wr_mem[{dst[11:2], 2'(k)}] == exp_b[k]) else begin
                err_cnt++;
                $display("error %0t: byte 0x%03h is %02h, expected %02h", $time,
                         {dst[11:2], 2'(k)}, wr_mem[{dst[11:2], 2'(k)}], exp_b[k]);
            end
        end
        assert (r_err == (src >= ERR_BASE)) else begin
            err_cnt++;
            $display("error %0t: read error flag %0b for 0x%03h", $time, r_err, src);
        end
        assert (w_err == (dst >= ERR_BASE)) else begin
            err_cnt++;
            $display("error %0t: write error flag %0b for 0x%03h", $time, w_err, dst);
        end
        assert (!buffer_busy_o) else begin
            err_cnt++;
            $display("error %0t: buffer still busy after copy", $time);
        end
        copy_cnt++;
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int    n;
        addr_t src;
        addr_t dst;
        lane_t off;
        ar_addr_i     = '0;
        ar_valid_i    = 1'b0;
        r_dp_offset_i = '0;
        r_dp_tailer_i = '0;
        r_dp_shift_i  = '0;
        r_dp_valid_i  = 1'b0;
        r_dp_ready_i  = 1'b0;
        aw_addr_i     = '0;
        aw_valid_i    = 1'b0;
        w_dp_offset_i = '0;
        w_dp_tailer_i = '0;
        w_dp_shift_i  = '0;
        w_dp_valid_i  = 1'b0;
        w_dp_ready_i  = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            rd_mem[i] = $random(seed);
        end
        for (int a = 0; a < 4096; a++) begin
            wr_mem[a] = 8'(a ^ (a >> 8)) ^ 8'hA5;
        end
        n = 0;
        while (rst_n_i !== 1'b1) begin
            if (n == TIMEOUT) abort_on_timeout("reset release");
            @(posedge clk_i);
            n++;
        end
        @(negedge clk_i);
        assert (!rd_req_o && !wr_req_o && !rd_rready_o && !r_dp_valid_o && !w_dp_valid_o
                && !r_dp_busy_o && !w_dp_busy_o && !buffer_busy_o) else begin
            err_cnt++;
            $display("error %0t: outputs not idle after reset", $time);
        end
        // Aligned beats
        run_copy(32'h000, 32'h100, 0, 0, 0, 0);
        run_copy(32'h004, 32'h104, 0, 0, 0, 0);
        run_copy(32'h3FC, 32'h0FC, 0, 0, 0, 0);
        // Error range on each side
        run_copy(32'hF10, 32'h200, 0, 0, 0, 0);
        run_copy(32'h204, 32'hF20, 1, 1, 2, 3);
        // Random lanes, shifts and addresses
        for (int i = 0; i < N_RANDOM; i++) begin
            src = addr_t'(rand_below(1024) * 4);
            dst = addr_t'(rand_below(1024) * 4);
            off = lane_t'(rand_below(4));
            run_copy(src, dst, off, lane_t'(rand_below(4 - off)),
                     lane_t'(rand_below(4)), lane_t'(rand_below(4)));
        end
        report_and_stop();
    end

endmodule
